/* design/axis_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_fifo
    import network_pkg::*;
#(
    parameter int DEPTH = 16  // power of two
) (
    input  logic       sys_reset,   // clock
    input  logic       net_clk,     // async reset
    input  logic       core_reset,  // sync clear
    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tlast,
    input  logic       s_tvalid,
    output logic       s_tready,
    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tlast,
    output logic       m_tvalid,
    input  logic       m_tready
);

    localparam int          AW     = $clog2(DEPTH);
    localparam logic [AW:0] FULL_N = (AW+1)'(DEPTH);

    axis_data_t    mem_data [DEPTH];
    axis_keep_t    mem_keep [DEPTH];
    logic          mem_last [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // words held
    logic          wr_en;
    logic          rd_en;

    assign s_tready = (count != FULL_N);  // back-pressure when full
    assign m_tvalid = (count != '0);
    assign wr_en    = s_tvalid && s_tready;
    assign rd_en    = m_tvalid && m_tready;

    // fall-through read of the head
    assign m_tdata = mem_data[rd_ptr];
    assign m_tkeep = mem_keep[rd_ptr];
    assign m_tlast = mem_last[rd_ptr];

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (core_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    always_ff @(posedge sys_reset) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= s_tdata;
            mem_keep[wr_ptr] <= s_tkeep;
            mem_last[wr_ptr] <= s_tlast;
        end
    end

    a_count: assert property (@(posedge sys_reset) disable iff (net_clk)
        count <= FULL_N)
        else $error("tx fifo count above depth");

endmodule

`default_nettype wire

/* design/core_reset_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module core_reset_sync (
    input  logic sys_reset,          // clock
    input  logic net_clk,            // active high async reset
    input  logic tx_link_reset,
    input  logic rx_link_reset,
    output logic core_reset,         // clear for the datapath
    output logic network_init_done
);

    logic link_reset;   // either side still in reset
    logic reset_meta;   // first stage

    assign link_reset = tx_link_reset | rx_link_reset;

    // a link reset sets both stages so init done drops at once
    // release walks through the two flops
    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            reset_meta <= 1'b1;
            core_reset <= 1'b1;
        end else begin
            reset_meta <= link_reset;
            core_reset <= reset_meta | link_reset;
        end
    end

    assign network_init_done = ~core_reset;

    // init done stays low for two edges after any link reset
    a_init_drop: assert property (@(posedge sys_reset) disable iff (net_clk)
        (link_reset || $past(link_reset)) |=> !network_init_done)
        else $error("init done high within two cycles of a link reset");

endmodule

`default_nettype wire

/* design/network_module.sv */
`timescale 1ns/1ps
`default_nettype none

module network_module
    import network_pkg::*;
#(
    parameter int TX_FIFO_DEPTH = 16,
    parameter int RX_FIFO_DEPTH = 32
) (
    input  logic        sys_reset,        // clock
    input  logic        net_clk,          // async reset
    input  logic        tx_link_reset,
    input  logic        rx_link_reset,
    output logic        network_init_done,
    // tx from user
    input  axis_data_t  s_axis_tdata,
    input  axis_keep_t  s_axis_tkeep,
    input  logic        s_axis_tvalid,
    input  logic        s_axis_tlast,
    output logic        s_axis_tready,
    // tx to mac
    output axis_data_t  tx_axis_tdata,
    output axis_keep_t  tx_axis_tkeep,
    output logic        tx_axis_tvalid,
    output logic        tx_axis_tlast,
    input  logic        tx_axis_tready,
    // rx from mac, no ready
    input  axis_data_t  rx_axis_tdata,
    input  axis_keep_t  rx_axis_tkeep,
    input  logic        rx_axis_tvalid,
    input  logic        rx_axis_tlast,
    input  logic        rx_axis_tuser,
    // rx to user
    output axis_data_t  m_axis_tdata,
    output axis_keep_t  m_axis_tkeep,
    output logic        m_axis_tvalid,
    output logic        m_axis_tlast,
    input  logic        m_axis_tready,
    output logic [15:0] rx_drop_count
);

    if ((TX_FIFO_DEPTH & (TX_FIFO_DEPTH - 1)) != 0 ||
        (RX_FIFO_DEPTH & (RX_FIFO_DEPTH - 1)) != 0 ||
        RX_FIFO_DEPTH < MIN_FRAME_WORDS) begin : g_bad_depth
        $error("fifo depths must be powers of two, rx depth at least one min frame");
    end

    logic       core_reset;
    axis_data_t pad_tdata;   // padder to tx fifo
    axis_keep_t pad_tkeep;
    logic       pad_tvalid;
    logic       pad_tlast;
    logic       pad_tready;

    core_reset_sync reset_sync_i (
        .sys_reset         (sys_reset),
        .net_clk           (net_clk),
        .tx_link_reset     (tx_link_reset),
        .rx_link_reset     (rx_link_reset),
        .core_reset        (core_reset),
        .network_init_done (network_init_done)
    );

    tx_frame_padder tx_pad_i (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .s_tdata    (s_axis_tdata),
        .s_tkeep    (s_axis_tkeep),
        .s_tvalid   (s_axis_tvalid),
        .s_tlast    (s_axis_tlast),
        .s_tready   (s_axis_tready),
        .m_tdata    (pad_tdata),
        .m_tkeep    (pad_tkeep),
        .m_tvalid   (pad_tvalid),
        .m_tlast    (pad_tlast),
        .m_tready   (pad_tready)
    );

    axis_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo_i (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .s_tdata    (pad_tdata),
        .s_tkeep    (pad_tkeep),
        .s_tlast    (pad_tlast),
        .s_tvalid   (pad_tvalid),
        .s_tready   (pad_tready),
        .m_tdata    (tx_axis_tdata),
        .m_tkeep    (tx_axis_tkeep),
        .m_tlast    (tx_axis_tlast),
        .m_tvalid   (tx_axis_tvalid),
        .m_tready   (tx_axis_tready)
    );

    rx_frame_filter #(.DEPTH(RX_FIFO_DEPTH)) rx_filter_i (
        .sys_reset  (sys_reset),
        .net_clk    (net_clk),
        .core_reset (core_reset),
        .rx_tdata   (rx_axis_tdata),
        .rx_tkeep   (rx_axis_tkeep),
        .rx_tvalid  (rx_axis_tvalid),
        .rx_tlast   (rx_axis_tlast),
        .rx_tuser   (rx_axis_tuser),
        .m_tdata    (m_axis_tdata),
        .m_tkeep    (m_axis_tkeep),
        .m_tlast    (m_axis_tlast),
        .m_tvalid   (m_axis_tvalid),
        .m_tready   (m_axis_tready),
        .drop_count (rx_drop_count)
    );

endmodule

`default_nettype wire

/* design/network_pkg.sv */
`default_nettype none

package network_pkg;

    // stream geometry
    localparam int AXIS_DATA_W = 64;               // one 64-bit word per beat
    localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;  // byte enables

    typedef logic [AXIS_DATA_W-1:0] axis_data_t;
    typedef logic [AXIS_KEEP_W-1:0] axis_keep_t;

    // framing rules for the tx side
    localparam int         MIN_FRAME_WORDS = 8;      // shortest frame on the wire
    localparam axis_keep_t MIN_LAST_KEEP   = 8'h0F;  // four low bytes on word eight

    // tx padder
    typedef enum logic {
        PAD_PASS,  // forward input words
        PAD_FILL   // emit zero words up to word eight
    } pad_state_e;

    // rx filter
    typedef enum logic {
        FLT_STORE,   // frame goes into the buffer
        FLT_DISCARD  // oversized, skip to last beat
    } filter_state_e;

endpackage

`default_nettype wire

/* design/rx_frame_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_frame_filter
    import network_pkg::*;
#(
    parameter int DEPTH = 32  // power of two
) (
    input  logic        sys_reset,   // clock
    input  logic        net_clk,     // async reset
    input  logic        core_reset,  // sync clear
    input  axis_data_t  rx_tdata,
    input  axis_keep_t  rx_tkeep,
    input  logic        rx_tvalid,
    input  logic        rx_tlast,
    input  logic        rx_tuser,    // error flag, last beat only
    output axis_data_t  m_tdata,
    output axis_keep_t  m_tkeep,
    output logic        m_tlast,
    output logic        m_tvalid,
    input  logic        m_tready,
    output logic [15:0] drop_count
);

    localparam int          AW     = $clog2(DEPTH);
    localparam logic [AW:0] FULL_N = (AW+1)'(DEPTH);

    axis_data_t    mem_data [DEPTH];
    axis_keep_t    mem_keep [DEPTH];
    logic          mem_last [DEPTH];
    filter_state_e state;
    logic [AW:0]   wr_ptr;      // speculative, extra wrap bit
    logic [AW:0]   commit_ptr;  // end of last good frame
    logic [AW:0]   rd_ptr;
    logic [AW:0]   used;        // words held, incl. uncommitted
    logic          full;
    logic          store_en;
    logic          rd_en;

    assign used     = wr_ptr - rd_ptr;
    assign full     = (used == FULL_N);
    assign store_en = !core_reset && rx_tvalid && (state == FLT_STORE) && !full;
    assign m_tvalid = (rd_ptr != commit_ptr);  // only committed words leave
    assign rd_en    = m_tvalid && m_tready;

    assign m_tdata = mem_data[rd_ptr[AW-1:0]];
    assign m_tkeep = mem_keep[rd_ptr[AW-1:0]];
    assign m_tlast = mem_last[rd_ptr[AW-1:0]];

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            state      <= FLT_STORE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop_count <= '0;
        end else if (core_reset) begin
            state      <= FLT_STORE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            drop_count <= '0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rx_tvalid) begin
                case (state)
                    FLT_STORE: begin
                        if (full) begin
                            wr_ptr <= commit_ptr;  // oversized, give space back now
                            if (rx_tlast) begin
                                drop_count <= drop_count + 1'b1;
                            end else begin
                                state <= FLT_DISCARD;
                            end
                        end else if (rx_tlast && rx_tuser) begin
                            wr_ptr     <= commit_ptr;  // bad frame, rewind
                            drop_count <= drop_count + 1'b1;
                        end else if (rx_tlast) begin
                            wr_ptr     <= wr_ptr + 1'b1;
                            commit_ptr <= wr_ptr + 1'b1;  // good frame visible
                        end else begin
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                    end
                    FLT_DISCARD: begin
                        if (rx_tlast) begin
                            drop_count <= drop_count + 1'b1;
                            state      <= FLT_STORE;
                        end
                    end
                    default: state <= FLT_STORE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_reset) begin
        if (store_en) begin
            mem_data[wr_ptr[AW-1:0]] <= rx_tdata;
            mem_keep[wr_ptr[AW-1:0]] <= rx_tkeep;
            mem_last[wr_ptr[AW-1:0]] <= rx_tlast;
        end
    end

    // read side never runs ahead of the commit point
    a_rd_commit: assert property (@(posedge sys_reset) disable iff (net_clk)
        (commit_ptr - rd_ptr) <= FULL_N)
        else $error("rx read pointer passed commit pointer");

endmodule

`default_nettype wire

/* design/tx_frame_padder.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_padder
    import network_pkg::*;
(
    input  logic       sys_reset,   // clock
    input  logic       net_clk,     // async reset
    input  logic       core_reset,  // sync clear
    input  axis_data_t s_tdata,
    input  axis_keep_t s_tkeep,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    output logic       s_tready,
    output axis_data_t m_tdata,
    output axis_keep_t m_tkeep,
    output logic       m_tvalid,
    output logic       m_tlast,
    input  logic       m_tready
);

    localparam int               CNT_W    = $clog2(MIN_FRAME_WORDS + 1);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(MIN_FRAME_WORDS - 1);  // index of word eight
    localparam logic [CNT_W-1:0] SAT_CNT  = CNT_W'(MIN_FRAME_WORDS);      // counter stops here

    pad_state_e       state;
    logic [CNT_W-1:0] word_cnt;     // words sent in this frame
    logic             out_free;     // output stage can take a word
    logic             in_fire;
    logic             fill_fire;
    logic             at_word8;     // next word is word eight
    logic             short_frame;  // last before word eight
    logic             thin_last;    // word eight with too few bytes
    axis_data_t       keep_mask;    // clears the bytes added to keep

    assign out_free    = !m_tvalid || m_tready;
    assign s_tready    = !core_reset && (state == PAD_PASS) && out_free;
    assign in_fire     = s_tvalid && s_tready;
    assign fill_fire   = !core_reset && (state == PAD_FILL) && out_free;
    assign at_word8    = (word_cnt == LAST_IDX);
    assign short_frame = (word_cnt < LAST_IDX);
    assign thin_last   = s_tlast && at_word8 && (s_tkeep < MIN_LAST_KEEP);

    always_comb begin
        for (int i = 0; i < AXIS_KEEP_W; i++) begin
            // zero only where keep gets widened
            keep_mask[i*8 +: 8] = (s_tkeep[i] || !MIN_LAST_KEEP[i]) ? 8'hFF : 8'h00;
        end
    end

    always_ff @(posedge sys_reset or posedge net_clk) begin
        if (net_clk) begin
            state    <= PAD_PASS;
            word_cnt <= '0;
            m_tvalid <= 1'b0;
        end else if (core_reset) begin
            state    <= PAD_PASS;
            word_cnt <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (in_fire || fill_fire) begin
                m_tvalid <= 1'b1;
            end else if (m_tready) begin
                m_tvalid <= 1'b0;  // word taken, nothing new
            end

            if (in_fire) begin
                if (s_tlast && short_frame) begin
                    state    <= PAD_FILL;  // pad the rest
                    word_cnt <= word_cnt + 1'b1;
                end else if (s_tlast) begin
                    word_cnt <= '0;        // frame done
                end else if (word_cnt != SAT_CNT) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (fill_fire) begin
                if (at_word8) begin
                    state    <= PAD_PASS;
                    word_cnt <= '0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // output payload, loaded together with valid
    always_ff @(posedge sys_reset) begin
        if (in_fire) begin
            m_tdata <= thin_last ? (s_tdata & keep_mask) : s_tdata;
            m_tkeep <= thin_last ? MIN_LAST_KEEP : s_tkeep;
            m_tlast <= s_tlast && !short_frame;  // early last moves to word eight
        end else if (fill_fire) begin
            m_tdata <= '0;
            m_tkeep <= '1;        // full padding word
            m_tlast <= at_word8;
        end
    end

    a_hold: assert property (@(posedge sys_reset) disable iff (net_clk || core_reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep)
                                  && $stable(m_tlast))
        else $error("padder output changed while stalled");

endmodule

`default_nettype wire

/* network_module.f */
design/network_pkg.sv
design/core_reset_sync.sv
design/tx_frame_padder.sv
design/axis_fifo.sv
design/rx_frame_filter.sv
design/network_module.sv
sim/tb_network_module.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the network_module testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_network
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_network_module \
    -f network_module.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG_FILE"; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL"
    exit 1
fi

/* sim/tb_network_module.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_network_module
    import network_pkg::*;
();

    localparam int TX_DEPTH      = 16;
    localparam int RX_DEPTH      = 32;
    localparam int SHORT_ROUNDS  = 2;   // passes over lengths 1..7
    localparam int TX_RANDOM     = 20;
    localparam int RX_RANDOM     = 30;
    localparam int TOTAL_FRAMES  = SHORT_ROUNDS * 7 + 4 + TX_RANDOM + RX_RANDOM + 4;
    localparam int WATCHDOG_CYCLES = 2000 * TOTAL_FRAMES + 1000;

    logic        sys_reset;           // clock
    logic        net_clk;             // async reset
    logic        tx_link_reset;
    logic        rx_link_reset;
    logic        network_init_done;
    axis_data_t  s_axis_tdata;
    axis_keep_t  s_axis_tkeep;
    logic        s_axis_tvalid;
    logic        s_axis_tlast;
    logic        s_axis_tready;
    axis_data_t  tx_axis_tdata;
    axis_keep_t  tx_axis_tkeep;
    logic        tx_axis_tvalid;
    logic        tx_axis_tlast;
    logic        tx_axis_tready;
    axis_data_t  rx_axis_tdata;
    axis_keep_t  rx_axis_tkeep;
    logic        rx_axis_tvalid;
    logic        rx_axis_tlast;
    logic        rx_axis_tuser;
    axis_data_t  m_axis_tdata;
    axis_keep_t  m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tready;
    logic [15:0] rx_drop_count;

    logic        link_any;            // either link still in reset
    logic        rx_drop_mark;        // current rx last beat belongs to a dropped frame
    logic [15:0] exp_drops = 16'd0;
    logic [72:0] tx_q [$];            // expected {last, keep, data}
    logic [72:0] rx_q [$];
    logic [72:0] tx_head;
    logic [72:0] rx_head;
    logic        tx_have;
    logic        rx_have;
    logic        tx_bp = 1'b0;        // random tx back-pressure on
    int          rx_ready_mode = 0;   // 0 high, 1 random, 2 held low
    int          error_count = 0;
    int          tests_ok = 0;
    int          tests_failed = 0;

    assign link_any = tx_link_reset || rx_link_reset;

    network_module #(
        .TX_FIFO_DEPTH (TX_DEPTH),
        .RX_FIFO_DEPTH (RX_DEPTH)
    ) dut_i (.*);

    initial begin
        sys_reset = 1'b0;
        forever #50 sys_reset = ~sys_reset;  // 100 ns period
    end

    task automatic log_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    a_reset_idle: assert property (@(posedge sys_reset) net_clk |=> !tx_axis_tvalid
        && !m_axis_tvalid && !s_axis_tready && !network_init_done && rx_drop_count == 16'd0)
        else log_error("outputs not idle after reset");
    a_init_low: assert property (@(posedge sys_reset) disable iff (net_clk)
        link_any |=> !network_init_done)
        else log_error("init done high after a link reset");
    a_init_early: assert property (@(posedge sys_reset) disable iff (net_clk)
        $past(link_any) && !link_any |=> !network_init_done)
        else log_error("init done rose one cycle early");
    a_init_rise: assert property (@(posedge sys_reset) disable iff (net_clk)
        !link_any && $past(!link_any) |=> network_init_done)
        else log_error("init done missing two cycles after link resets cleared");
    a_tx_word: assert property (@(posedge sys_reset) disable iff (net_clk)
        tx_axis_tvalid && tx_axis_tready |->
        tx_have && {tx_axis_tlast, tx_axis_tkeep, tx_axis_tdata} == tx_head)
        else log_error($sformatf("tx word %h/%h/%b, expected %h", tx_axis_tdata,
            tx_axis_tkeep, tx_axis_tlast, tx_head));
    a_rx_word: assert property (@(posedge sys_reset) disable iff (net_clk)
        m_axis_tvalid && m_axis_tready |->
        rx_have && {m_axis_tlast, m_axis_tkeep, m_axis_tdata} == rx_head)
        else log_error($sformatf("rx word %h/%h/%b, expected %h", m_axis_tdata,
            m_axis_tkeep, m_axis_tlast, rx_head));
    a_drops: assert property (@(posedge sys_reset) disable iff (net_clk)
        rx_drop_count == exp_drops)
        else log_error($sformatf("drop count %0d, expected %0d", rx_drop_count, exp_drops));

    // drop counted on the edge that takes the last beat, same as the dut
    always @(posedge sys_reset) begin
        if (rx_axis_tvalid && rx_axis_tlast && rx_drop_mark) begin
            exp_drops <= exp_drops + 16'd1;
        end
    end

    // readies and queue heads move on the falling edge only
    initial begin : ready_and_heads
        logic tx_fire;
        logic rx_fire;
        tx_fire = 1'b0;
        rx_fire = 1'b0;
        tx_axis_tready = 1'b1;
        m_axis_tready  = 1'b1;
        tx_have = 1'b0;
        rx_have = 1'b0;
        tx_head = '0;
        rx_head = '0;
        forever begin
            @(negedge sys_reset);
            if (tx_fire && tx_q.size() != 0) void'(tx_q.pop_front());  // taken last edge
            if (rx_fire && rx_q.size() != 0) void'(rx_q.pop_front());
            tx_axis_tready = tx_bp ? ($urandom_range(0, 3) != 0) : 1'b1;
            m_axis_tready  = (rx_ready_mode == 0) ? 1'b1 :
                             (rx_ready_mode == 1) ? ($urandom_range(0, 2) != 0) : 1'b0;
            tx_fire = tx_axis_tvalid && tx_axis_tready;  // transfer on next edge
            rx_fire = m_axis_tvalid && m_axis_tready;
            tx_have = (tx_q.size() != 0);
            rx_have = (rx_q.size() != 0);
            tx_head = tx_have ? tx_q[0] : '0;
            rx_head = rx_have ? rx_q[0] : '0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_reset);
        $display("run timed out after %0d cycles, a handshake never completed",
            WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic axis_data_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic axis_keep_t rand_last_keep();
        return 8'hFF >> $urandom_range(0, 7);  // contiguous from byte 0
    endfunction

    task automatic drive_tx_word(input axis_data_t d, input axis_keep_t k, input logic last);
        logic taken;
        s_axis_tdata  = d;
        s_axis_tkeep  = k;
        s_axis_tlast  = last;
        s_axis_tvalid = 1'b1;
        do begin
            taken = s_axis_tready;  // steady until the next rising edge
            @(negedge sys_reset);
        end while (!taken);
    endtask

    task automatic send_tx_frame(input int len, input axis_keep_t last_keep);
        axis_data_t d;
        axis_keep_t k;
        axis_data_t exp_d;
        axis_keep_t exp_k;
        for (int i = 0; i < len; i++) begin
            d     = rand_word();
            k     = (i == len - 1) ? last_keep : 8'hFF;
            exp_d = d;
            exp_k = k;
            if (len == MIN_FRAME_WORDS && i == len - 1 && k < MIN_LAST_KEEP) begin
                exp_k = MIN_LAST_KEEP;  // thin word eight widened
                for (int b = 0; b < 4; b++) begin
                    if (!k[b]) exp_d[b*8 +: 8] = 8'h00;  // added bytes read as zero
                end
            end
            tx_q.push_back({(i == len - 1) && (len >= MIN_FRAME_WORDS), exp_k, exp_d});
            drive_tx_word(d, k, i == len - 1);
        end
        for (int i = len; i < MIN_FRAME_WORDS; i++) begin
            tx_q.push_back({(i == MIN_FRAME_WORDS - 1), 8'hFF, 64'h0});  // padding
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    task automatic send_rx_frame(input int len, input logic err);
        logic       dropped;
        logic       last;
        axis_data_t d;
        axis_keep_t k;
        dropped = err || (rx_q.size() + len > RX_DEPTH);  // bad flag or no room
        for (int i = 0; i < len; i++) begin
            d    = rand_word();
            last = (i == len - 1);
            k    = last ? rand_last_keep() : 8'hFF;
            if (!dropped) rx_q.push_back({last, k, d});
            rx_axis_tdata  = d;
            rx_axis_tkeep  = k;
            rx_axis_tlast  = last;
            rx_axis_tuser  = last ? err : ($urandom_range(0, 1) == 1);  // ignored mid frame
            rx_axis_tvalid = 1'b1;
            rx_drop_mark   = last && dropped;
            @(negedge sys_reset);
        end
        rx_axis_tvalid = 1'b0;
        rx_axis_tlast  = 1'b0;
        rx_axis_tuser  = 1'b0;
        rx_drop_mark   = 1'b0;
    endtask

    task automatic wait_tx_drained();
        while (tx_q.size() != 0) @(negedge sys_reset);
        repeat (3) @(negedge sys_reset);
    endtask

    task automatic wait_rx_drained();
        while (rx_q.size() != 0) @(negedge sys_reset);
        repeat (3) @(negedge sys_reset);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_ok++;
            $display("test %-28s ok", name);
        end else begin
            tests_failed++;
            $display("test %-28s FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin : stimulus
        int errs;
        void'($urandom(12));
        net_clk = 1'b1;
        tx_link_reset = 1'b1;
        rx_link_reset = 1'b1;
        s_axis_tdata = '0;
        s_axis_tkeep = '0;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        rx_axis_tdata = '0;
        rx_axis_tkeep = '0;
        rx_axis_tvalid = 1'b0;
        rx_axis_tlast = 1'b0;
        rx_axis_tuser = 1'b0;
        rx_drop_mark = 1'b0;

        errs = error_count;
        repeat (4) @(negedge sys_reset);
        net_clk = 1'b0;
        repeat (3) @(negedge sys_reset);
        tx_link_reset = 1'b0;
        repeat (2) @(negedge sys_reset);
        rx_link_reset = 1'b0;
        while (!network_init_done) @(negedge sys_reset);
        repeat (3) @(negedge sys_reset);
        rx_link_reset = 1'b1;  // link drops, core back in reset
        repeat (2) @(negedge sys_reset);
        rx_link_reset = 1'b0;
        while (!network_init_done) @(negedge sys_reset);
        repeat (2) @(negedge sys_reset);
        report_test("reset and init done", errs);

        errs = error_count;
        for (int r = 0; r < SHORT_ROUNDS; r++) begin
            for (int len = 1; len < MIN_FRAME_WORDS; len++) begin
                send_tx_frame(len, rand_last_keep());
            end
        end
        wait_tx_drained();
        report_test("tx short frame padding", errs);

        errs = error_count;
        tx_bp = 1'b1;
        send_tx_frame(8, 8'h01);
        send_tx_frame(8, 8'h03);
        send_tx_frame(8, 8'h07);
        send_tx_frame(8, 8'hFF);
        for (int i = 0; i < TX_RANDOM; i++) begin
            send_tx_frame($urandom_range(1, 20), rand_last_keep());
        end
        wait_tx_drained();
        tx_bp = 1'b0;
        report_test("tx keep fix and back-pressure", errs);

        errs = error_count;
        rx_ready_mode = 1;
        for (int i = 0; i < RX_RANDOM; i++) begin
            wait_rx_drained();  // empty buffer, only the flag decides
            send_rx_frame($urandom_range(1, 20), (i % 3) == 1);
        end
        wait_rx_drained();
        report_test("rx error frame filter", errs);

        errs = error_count;
        rx_ready_mode = 2;
        repeat (2) @(negedge sys_reset);
        send_rx_frame(4, 1'b0);             // committed, waits
        send_rx_frame(RX_DEPTH + 8, 1'b0);  // overflows
        send_rx_frame(RX_DEPTH - 4, 1'b0);  // fills buffer exactly
        send_rx_frame(2, 1'b0);             // no room left
        repeat (5) @(negedge sys_reset);
        rx_ready_mode = 0;
        wait_rx_drained();
        report_test("rx oversize drop", errs);

        $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
